// ==== fetch_params.svh ====
// fetch subsystem parameters: reset vector, sram geometry and datapath widths
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first instruction address after reset
`define FS_PC_RESETVAL  32'h8000_0000

// sram geometry, counted in 64-bit words
`define FS_MEM_DEPTH    1024
`define FS_MEM_AW       10      // word index bits, byte addr [12:3]

// datapath widths
`define FS_INST_WD      32
`define FS_PC_WD        32
`define FS_SRAM_DATA_WD 64      // two instructions per sram word

`endif

// ==== fetch_pkg.sv ====
// fetch package: bus structs shared by fetch stage, data port, arbiter and sram
`default_nettype none

`include "fetch_params.svh"

package fetch_pkg;

  // branch bus coming back from decode
  typedef struct packed {
    logic                 stall;    // keep fetch idle
    logic                 sel;      // one-cycle redirect pulse
    logic [`FS_PC_WD-1:0] target;
  } br_bus_t;

  // fetch to decode payload
  typedef struct packed {
    logic [`FS_INST_WD-1:0] inst;
    logic [`FS_PC_WD-1:0]   pc;
  } fs_to_ds_bus_t;

  // one access on the shared sram port
  typedef struct packed {
    logic                            we;
    logic [`FS_PC_WD-1:0]            addr;   // byte address
    logic [`FS_SRAM_DATA_WD-1:0]     wdata;
    logic [`FS_SRAM_DATA_WD/8-1:0]   wstrb;  // one bit per byte lane
  } mem_req_t;

  // word load or store from the data side
  typedef struct packed {
    logic                   we;
    logic [`FS_PC_WD-1:0]   addr;
    logic [`FS_INST_WD-1:0] wdata;   // data word is instruction sized
  } lsu_req_t;

endpackage

`default_nettype wire

// ==== fetch_pc.sv ====
// program counter: pc register, next fetch address select and pending redirect latch
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_pc (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_load,        // fetch issued this cycle
  input  logic                 i_br_sel,      // redirect pulse from decode
  input  logic [`FS_PC_WD-1:0] i_br_target,
  output logic [`FS_PC_WD-1:0] o_pc,          // pc of the instruction in the stage
  output logic [`FS_PC_WD-1:0] o_fetch_addr   // address of the next fetch
);

  logic [`FS_PC_WD-1:0] pc_q;
  logic                 br_pend_q;
  logic [`FS_PC_WD-1:0] br_target_q;

  // a live redirect is newer than a latched one
  always_comb begin
    if (i_br_sel) begin
      o_fetch_addr = i_br_target;
    end else if (br_pend_q) begin
      o_fetch_addr = br_target_q;
    end else begin
      o_fetch_addr = pc_q + 32'd4;   // sequential
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q <= `FS_PC_RESETVAL - 32'd4;   // so first fetch hits the reset vector
    end else if (i_load) begin
      pc_q <= o_fetch_addr;
    end
  end

  // redirect seen while no fetch issues waits here for the next one
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      br_pend_q <= 1'b0;
    end else if (i_load) begin
      br_pend_q <= 1'b0;
    end else if (i_br_sel) begin
      br_pend_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_load && i_br_sel) begin
      br_target_q <= i_br_target;
    end
  end

  assign o_pc = pc_q;

endmodule

`default_nettype wire

// ==== fetch_if_stage.sv ====
// instruction fetch stage: valid and allow-in control, half-word select and instruction hold
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_if_stage (
  input  logic                        i_clk,
  input  logic                        i_reset,
  input  logic                        i_ds_allowin,
  input  fetch_pkg::br_bus_t          i_br_bus,
  input  logic                        i_fetch_gnt,
  input  logic [`FS_SRAM_DATA_WD-1:0] i_sram_rdata,
  output logic                        o_fetch_req,
  output fetch_pkg::mem_req_t         o_fetch_mem,
  output logic                        o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_bus_t    o_fs_to_ds_bus
);

  logic                   fs_valid_q;
  logic                   fs_fresh_q;    // first valid cycle, sram data still live
  logic                   fs_allowin;
  logic                   fetch_go;
  logic [`FS_PC_WD-1:0]   fs_pc;
  logic [`FS_PC_WD-1:0]   fetch_addr;
  logic [`FS_INST_WD-1:0] inst_sel;
  logic [`FS_INST_WD-1:0] inst_hold_q;

  // empty stage, or current instruction leaves this cycle
  assign fs_allowin  = !fs_valid_q || i_ds_allowin;
  assign o_fetch_req = fs_allowin && !i_br_bus.stall;
  assign fetch_go    = o_fetch_req && i_fetch_gnt;

  fetch_pc u_pc (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_load       (fetch_go),
    .i_br_sel     (i_br_bus.sel),
    .i_br_target  (i_br_bus.target),
    .o_pc         (fs_pc),
    .o_fetch_addr (fetch_addr)
  );

  // instruction fetch is always a plain read
  always_comb begin
    o_fetch_mem.we    = 1'b0;
    o_fetch_mem.addr  = fetch_addr;
    o_fetch_mem.wdata = '0;
    o_fetch_mem.wstrb = '0;
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid_q <= 1'b0;
      fs_fresh_q <= 1'b0;
    end else begin
      fs_fresh_q <= fetch_go;
      if (fs_allowin) begin
        fs_valid_q <= fetch_go;   // denied or stalled leaves a bubble
      end
    end
  end

  // pc[2] picks which half of the 64-bit word holds the instruction
  assign inst_sel = fs_pc[2] ? i_sram_rdata[`FS_SRAM_DATA_WD-1:`FS_INST_WD]
                             : i_sram_rdata[`FS_INST_WD-1:0];

  // sram output may be overwritten by a data access, keep a copy
  always_ff @(posedge i_clk) begin
    if (fs_fresh_q) begin
      inst_hold_q <= inst_sel;
    end
  end

  assign o_fs_to_ds_valid    = fs_valid_q;
  assign o_fs_to_ds_bus.inst = fs_fresh_q ? inst_sel : inst_hold_q;
  assign o_fs_to_ds_bus.pc   = fs_pc;

endmodule

`default_nettype wire

// ==== fetch_lsu_port.sv ====
// data port: holds one word load or store until the arbiter grants it, then returns the response
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_lsu_port (
  input  logic                        i_clk,
  input  logic                        i_reset,
  input  logic                        i_req_valid,   // request strobe
  input  fetch_pkg::lsu_req_t         i_req,
  input  logic                        i_gnt,
  input  logic [`FS_SRAM_DATA_WD-1:0] i_sram_rdata,
  output logic                        o_busy,
  output logic                        o_mem_req_valid,
  output fetch_pkg::mem_req_t         o_mem_req,
  output logic                        o_resp_valid,
  output logic [`FS_INST_WD-1:0]      o_resp_rdata
);

  import fetch_pkg::*;

  logic     busy_q;
  logic     resp_q;
  logic     accept;
  logic     hi_half;
  lsu_req_t req_q;

  assign accept = i_req_valid && !busy_q;   // strobes while busy are dropped

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy_q <= 1'b0;
      resp_q <= 1'b0;
    end else begin
      resp_q <= busy_q && i_gnt;
      if (busy_q && i_gnt) begin
        busy_q <= 1'b0;
      end else if (accept) begin
        busy_q <= 1'b1;
      end
    end
  end

  // still valid during the response cycle
  always_ff @(posedge i_clk) begin
    if (accept) begin
      req_q <= i_req;
    end
  end

  assign hi_half = req_q.addr[2];

  // store word goes into the lane picked by addr[2]
  always_comb begin
    o_mem_req.we   = req_q.we;
    o_mem_req.addr = req_q.addr;
    if (hi_half) begin
      o_mem_req.wdata = {req_q.wdata, {`FS_INST_WD{1'b0}}};
    end else begin
      o_mem_req.wdata = {{`FS_INST_WD{1'b0}}, req_q.wdata};
    end
    if (!req_q.we) begin
      o_mem_req.wstrb = 8'h00;
    end else begin
      o_mem_req.wstrb = hi_half ? 8'hf0 : 8'h0f;
    end
  end

  always_comb begin
    if (req_q.we) begin
      o_resp_rdata = '0;   // stores answer with zero
    end else if (hi_half) begin
      o_resp_rdata = i_sram_rdata[`FS_SRAM_DATA_WD-1:`FS_INST_WD];
    end else begin
      o_resp_rdata = i_sram_rdata[`FS_INST_WD-1:0];
    end
  end

  assign o_busy          = busy_q;
  assign o_mem_req_valid = busy_q;
  assign o_resp_valid    = resp_q;

endmodule

`default_nettype wire

// ==== fetch_mem_arbiter.sv ====
// round-robin arbiter putting fetch and data requests onto the one sram port
`timescale 1ns/10ps
`default_nettype none

module fetch_mem_arbiter (
  input  logic                i_clk,
  input  logic                i_reset,
  input  logic                i_fetch_req,
  input  fetch_pkg::mem_req_t i_fetch_mem,
  input  logic                i_lsu_req,
  input  fetch_pkg::mem_req_t i_lsu_mem,
  output logic                o_fetch_gnt,
  output logic                o_lsu_gnt,
  output logic                o_sram_en,
  output fetch_pkg::mem_req_t o_sram_req
);

  logic lsu_won_q;   // data port took the last conflict
  logic conflict;

  assign conflict = i_fetch_req && i_lsu_req;

  // loser of the previous conflict wins this one
  assign o_fetch_gnt = i_fetch_req && (!i_lsu_req || lsu_won_q);
  assign o_lsu_gnt   = i_lsu_req && (!i_fetch_req || !lsu_won_q);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      lsu_won_q <= 1'b1;   // fetch gets the first conflict
    end else if (conflict) begin
      lsu_won_q <= o_lsu_gnt;
    end
  end

  assign o_sram_en  = i_fetch_req || i_lsu_req;
  assign o_sram_req = o_lsu_gnt ? i_lsu_mem : i_fetch_mem;

endmodule

`default_nettype wire

// ==== fetch_sram.sv ====
// single-port 64-bit synchronous sram with byte write strobes, read returns old data
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_sram (
  input  logic                        i_clk,
  input  logic                        i_en,
  input  fetch_pkg::mem_req_t         i_req,
  output logic [`FS_SRAM_DATA_WD-1:0] o_rdata
);

  logic [`FS_SRAM_DATA_WD-1:0] mem [`FS_MEM_DEPTH];
  logic [`FS_MEM_AW-1:0]       idx;

  // byte address to word index, upper bits ignored so it wraps
  assign idx = i_req.addr[`FS_MEM_AW+2:3];

  always_ff @(posedge i_clk) begin
    if (i_en) begin
      o_rdata <= mem[idx];   // read before write
      if (i_req.we) begin
        for (int b = 0; b < `FS_SRAM_DATA_WD/8; b++) begin
          if (i_req.wstrb[b]) begin
            mem[idx][8*b +: 8] <= i_req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== fetch_subsys_top.sv ====
// fetch subsystem top: fetch stage and data port sharing one sram through the arbiter
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module fetch_subsys_top (
  input  logic                     i_clk,
  input  logic                     i_reset,
  // decode side
  input  logic                     i_ds_allowin,
  input  fetch_pkg::br_bus_t       i_br_bus,
  output logic                     o_fs_to_ds_valid,
  output fetch_pkg::fs_to_ds_bus_t o_fs_to_ds_bus,
  // data side
  input  logic                     i_lsu_req_valid,
  input  fetch_pkg::lsu_req_t      i_lsu_req,
  output logic                     o_lsu_busy,
  output logic                     o_lsu_resp_valid,
  output logic [`FS_INST_WD-1:0]   o_lsu_resp_rdata
);

  import fetch_pkg::*;

  mem_req_t                    fetch_mem;
  mem_req_t                    lsu_mem;
  mem_req_t                    sram_req;
  logic                        fetch_req;
  logic                        fetch_gnt;
  logic                        lsu_req;
  logic                        lsu_gnt;
  logic                        sram_en;
  logic [`FS_SRAM_DATA_WD-1:0] sram_rdata;   // shared by both requesters

  fetch_if_stage u_if_stage (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_ds_allowin     (i_ds_allowin),
    .i_br_bus         (i_br_bus),
    .i_fetch_gnt      (fetch_gnt),
    .i_sram_rdata     (sram_rdata),
    .o_fetch_req      (fetch_req),
    .o_fetch_mem      (fetch_mem),
    .o_fs_to_ds_valid (o_fs_to_ds_valid),
    .o_fs_to_ds_bus   (o_fs_to_ds_bus)
  );

  fetch_lsu_port u_lsu_port (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_req_valid     (i_lsu_req_valid),
    .i_req           (i_lsu_req),
    .i_gnt           (lsu_gnt),
    .i_sram_rdata    (sram_rdata),
    .o_busy          (o_lsu_busy),
    .o_mem_req_valid (lsu_req),
    .o_mem_req       (lsu_mem),
    .o_resp_valid    (o_lsu_resp_valid),
    .o_resp_rdata    (o_lsu_resp_rdata)
  );

  fetch_mem_arbiter u_arbiter (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_fetch_req (fetch_req),
    .i_fetch_mem (fetch_mem),
    .i_lsu_req   (lsu_req),
    .i_lsu_mem   (lsu_mem),
    .o_fetch_gnt (fetch_gnt),
    .o_lsu_gnt   (lsu_gnt),
    .o_sram_en   (sram_en),
    .o_sram_req  (sram_req)
  );

  fetch_sram u_sram (
    .i_clk   (i_clk),
    .i_en    (sram_en),
    .i_req   (sram_req),
    .o_rdata (sram_rdata)
  );

endmodule

`default_nettype wire

// ==== tb_fetch_subsys.sv ====
// fetch subsystem testbench: random fetch, redirect and load traffic against a memory model
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module tb_fetch_subsys;

  import fetch_pkg::*;

  localparam int N_STORES = 2 * `FS_MEM_DEPTH;   // one store per instruction slot
  localparam int N_SEQ    = 150;
  localparam int N_HOLD   = 80;
  localparam int N_BR     = 120;
  localparam int N_FETCH  = N_SEQ + N_HOLD + N_BR;
  localparam int N_LOADS  = 40;
  localparam int TIMEOUT  = 4 * (N_STORES + N_FETCH + N_LOADS) + 100;

  logic          clk;
  logic          reset;
  logic          ds_allowin;
  br_bus_t       br_bus;
  logic          lsu_req_valid;
  lsu_req_t      lsu_req;
  logic          fs_to_ds_valid;
  fs_to_ds_bus_t fs_to_ds_bus;
  logic          lsu_busy;
  logic          lsu_resp_valid;
  logic [31:0]   lsu_resp_rdata;

  logic [63:0]   mem_model [`FS_MEM_DEPTH];
  logic [31:0]   resp_exp [$];   // answers still owed by the data port
  logic [31:0]   last_pc;
  logic          first_xfer;
  logic          br_pend;
  logic [31:0]   br_target;
  logic          br_seq_seen;    // the one sequential pc allowed after a redirect
  logic          hold_valid;
  fs_to_ds_bus_t hold_bus;
  int            xfer_count;
  int            cycle_count = 0;
  integer        seed;
  string         test_name;
  int            test_errs;
  int            tests_ok;
  int            tests_bad;

  fetch_subsys_top dut0 (
    .i_clk            (clk),
    .i_reset          (reset),
    .i_ds_allowin     (ds_allowin),
    .i_br_bus         (br_bus),
    .o_fs_to_ds_valid (fs_to_ds_valid),
    .o_fs_to_ds_bus   (fs_to_ds_bus),
    .i_lsu_req_valid  (lsu_req_valid),
    .i_lsu_req        (lsu_req),
    .o_lsu_busy       (lsu_busy),
    .o_lsu_resp_valid (lsu_resp_valid),
    .o_lsu_resp_rdata (lsu_resp_rdata)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles, in test %s", TIMEOUT, test_name);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_eq(input string what, input logic [31:0] exp_val,
                          input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string next_name);
    if (test_errs == 0) begin
      $display("test %s ok", test_name);
      tests_ok++;
    end else begin
      $display("test %s failed with %0d errors", test_name, test_errs);
      tests_bad++;
    end
    test_errs = 0;
    test_name = next_name;
  endtask

  // sram word index is byte address [12:3], pc[2] picks the half
  function automatic logic [31:0] model_read(input logic [31:0] addr);
    logic [63:0] word;
    word = mem_model[addr[`FS_MEM_AW+2:3]];
    return addr[2] ? word[63:32] : word[31:0];
  endfunction

  task automatic check_xfer();
    logic [31:0] pc;
    pc = fs_to_ds_bus.pc;
    check_eq("inst", model_read(pc), fs_to_ds_bus.inst);
    if (first_xfer) begin
      check_eq("reset_pc", `FS_PC_RESETVAL, pc);
      first_xfer = 1'b0;
    end else if (br_pend) begin
      if (pc == br_target) begin
        br_pend = 1'b0;
      end else if (pc == last_pc + 32'd4 && !br_seq_seen) begin
        br_seq_seen = 1'b1;   // already in flight when the redirect came
      end else begin
        check_eq("branch_pc", br_target, pc);
      end
    end else begin
      check_eq("seq_pc", last_pc + 32'd4, pc);
    end
    last_pc = pc;
    xfer_count++;
  endtask

  // check this cycle against the inputs already driven, then move to the next falling edge
  task automatic step();
    if (hold_valid) begin
      check_eq("held_valid", 32'd1, 32'(fs_to_ds_valid));
      check_eq("held_inst", hold_bus.inst, fs_to_ds_bus.inst);
      check_eq("held_pc", hold_bus.pc, fs_to_ds_bus.pc);
    end
    if (fs_to_ds_valid && ds_allowin) begin
      check_xfer();
    end
    hold_valid = fs_to_ds_valid && !ds_allowin;
    hold_bus   = fs_to_ds_bus;
    if (br_bus.sel) begin
      br_pend     = 1'b1;
      br_target   = br_bus.target;
      br_seq_seen = 1'b0;
    end
    if (lsu_resp_valid) begin
      if (resp_exp.size() == 0) begin
        $display("Error %s: response pulse with no open request", test_name);
        test_errs++;
      end else begin
        check_eq("lsu_rdata", resp_exp.pop_front(), lsu_resp_rdata);
      end
    end
    @(negedge clk);
    br_bus.sel    = 1'b0;   // strobes last one cycle
    lsu_req_valid = 1'b0;
  endtask

  // caller makes sure the port is not busy
  task automatic issue_lsu(input logic we, input logic [31:0] addr, input logic [31:0] data);
    lsu_req_valid = 1'b1;
    lsu_req.we    = we;
    lsu_req.addr  = addr;
    lsu_req.wdata = data;
    if (!we) begin
      resp_exp.push_back(model_read(addr));
    end else begin
      if (addr[2]) begin
        mem_model[addr[`FS_MEM_AW+2:3]][63:32] = data;
      end else begin
        mem_model[addr[`FS_MEM_AW+2:3]][31:0] = data;
      end
      resp_exp.push_back(32'h0);
    end
  endtask

  // stall with decode accepting, stage must drain
  task automatic stall_window();
    br_bus.stall = 1'b1;
    ds_allowin   = 1'b1;
    step();
    step();
    check_eq("stall_drain", 32'd0, 32'(fs_to_ds_valid));
    br_bus.stall = 1'b0;
  endtask

  task automatic run_mixed(input int n_xfer, input logic [3:0] allow_lvl,
                           input logic do_branch, input int n_loads);
    int          xfer_end;
    int          loads_sent;
    logic [31:0] r;
    logic [31:0] r2;
    xfer_end   = xfer_count + n_xfer;
    loads_sent = 0;
    while (xfer_count < xfer_end || loads_sent < n_loads || resp_exp.size() != 0) begin
      r  = $random(seed);
      r2 = $random(seed);
      ds_allowin = (r[3:0] < allow_lvl);
      if (do_branch && r[15:12] == 4'd0) begin
        stall_window();
      end else begin
        if (do_branch && !br_pend && r[6:4] == 3'd0) begin
          br_bus.sel    = 1'b1;
          br_bus.target = `FS_PC_RESETVAL + {19'd0, r2[12:2], 2'b00};
        end
        if (loads_sent < n_loads && !lsu_busy && r[9:8] == 2'd0) begin
          issue_lsu(1'b0, `FS_PC_RESETVAL + {19'd0, r2[28:18], 2'b00}, 32'h0);
          loads_sent++;
        end
        step();
      end
    end
  endtask

  initial begin
    seed          = 32'h98bb0853;
    clk           = 1'b0;
    reset         = 1'b1;
    ds_allowin    = 1'b1;
    br_bus        = '0;
    br_bus.stall  = 1'b1;   // fetch idle until memory is loaded
    lsu_req_valid = 1'b0;
    lsu_req       = '0;
    first_xfer    = 1'b1;
    br_pend       = 1'b0;
    br_seq_seen   = 1'b0;
    hold_valid    = 1'b0;
    last_pc       = '0;
    xfer_count    = 0;
    test_errs     = 0;
    tests_ok      = 0;
    tests_bad     = 0;
    test_name     = "reset";
    repeat (5) @(negedge clk);
    reset = 1'b0;
    check_eq("fs_to_ds_valid", 32'd0, 32'(fs_to_ds_valid));
    check_eq("lsu_busy", 32'd0, 32'(lsu_busy));
    check_eq("lsu_resp_valid", 32'd0, 32'(lsu_resp_valid));
    finish_test("preload");

    for (int i = 0; i < N_STORES; i++) begin
      while (lsu_busy) begin
        step();
      end
      issue_lsu(1'b1, `FS_PC_RESETVAL + 32'(4 * i), $random(seed));
      step();
    end
    while (resp_exp.size() != 0) begin
      step();
    end
    finish_test("fetch_stream");

    br_bus.stall = 1'b0;
    run_mixed(N_SEQ, 4'd12, 1'b0, 0);
    finish_test("backpressure_hold");
    run_mixed(N_HOLD, 4'd4, 1'b0, 0);   // decode mostly refuses
    finish_test("branch_redirect");
    run_mixed(N_BR, 4'd12, 1'b1, 0);
    finish_test("concurrent_loads");
    run_mixed(0, 4'd12, 1'b0, N_LOADS);
    finish_test("done");

    $display("tests passed %0d failed %0d", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fetch_subsys.f ====
+incdir+.
fetch_pkg.sv
fetch_pc.sv
fetch_if_stage.sv
fetch_lsu_port.sv
fetch_mem_arbiter.sv
fetch_sram.sv
fetch_subsys_top.sv
tb_fetch_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv -f fetch_subsys.f --top-module tb_fetch_subsys \
  -Mdir obj_dir -o sim_fetch_subsys > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see build.log"
  exit 1
fi

./obj_dir/sim_fetch_subsys > sim.log 2>&1
if [ $? -ne 0 ]; then
  echo "simulation exited with an error, see sim.log"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure, see sim.log"
  exit 1
fi

echo "simulation finished without failures"
exit 0
